// File: hw/mini_mcu_settings.svh
/*
  mini MCU build settings
  RAM bank geometry and the system memory map
*/
`ifndef MINI_MCU_SETTINGS_SVH
`define MINI_MCU_SETTINGS_SVH

// RAM banks, one word wide each
`define NUM_BANKS 2
`define BANK_WORDS 256

// always-on peripherals live at bit 16
`define AO_BASE 32'h0001_0000

// address bit that picks the RAM bank
`define RAM_BANK_BIT 10

`endif

// File: hw/mini_mcu_pkg.sv
/*
  mini MCU shared types
  OBI request/response structs and the bus slave select
*/
`default_nettype none

package mini_mcu_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // decoder target on the system bus
  typedef enum logic {
    RAM,
    AO
  } slave_sel_e;

endpackage

`default_nettype wire

// File: hw/system_bus.sv
/*
  system bus
  fixed-priority arbiter for two OBI masters, decoder for RAM and AO slaves
*/
`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_settings.svh"

module system_bus
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  obi_req_t  ext_master_req_i,
  output obi_resp_t ext_master_resp_o,
  input  obi_req_t  dma_req_i,
  output obi_resp_t dma_resp_o,
  output obi_req_t  ram_req_o,
  input  obi_resp_t ram_resp_i,
  output obi_req_t  ao_req_o,
  input  obi_resp_t ao_resp_i
);

  obi_req_t   bus_req;
  slave_sel_e bus_sel;
  logic       dma_won;
  logic       bus_gnt;
  logic       pend_q;
  logic       pend_dma_q;
  slave_sel_e pend_sel_q;
  obi_resp_t  slave_resp;

  // external master first, DMA only when it is quiet
  assign dma_won = dma_req_i.req & ~ext_master_req_i.req;
  assign bus_req = dma_won ? dma_req_i : ext_master_req_i;
  assign bus_sel = ((bus_req.addr & `AO_BASE) != 32'h0) ? AO : RAM;

  always_comb begin
    ram_req_o     = bus_req;
    ao_req_o      = bus_req;
    ram_req_o.req = bus_req.req & (bus_sel == RAM);
    ao_req_o.req  = bus_req.req & (bus_sel == AO);
  end

  assign bus_gnt = bus_req.req & ((bus_sel == AO) ? ao_resp_i.gnt : ram_resp_i.gnt);

  // one outstanding transaction: remember who got it and where it went
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q     <= 1'b0;
      pend_dma_q <= 1'b0;
      pend_sel_q <= RAM;
    end else begin
      pend_q <= bus_gnt;
      if (bus_gnt) begin
        pend_dma_q <= dma_won;
        pend_sel_q <= bus_sel;
      end
    end
  end

  assign slave_resp = (pend_sel_q == AO) ? ao_resp_i : ram_resp_i;

  always_comb begin
    ext_master_resp_o.gnt    = bus_gnt & ~dma_won;
    ext_master_resp_o.rvalid = pend_q & ~pend_dma_q & slave_resp.rvalid;
    ext_master_resp_o.rdata  = slave_resp.rdata;
    dma_resp_o.gnt           = bus_gnt & dma_won;
    dma_resp_o.rvalid        = pend_q & pend_dma_q & slave_resp.rvalid;
    dma_resp_o.rdata         = slave_resp.rdata;
  end

endmodule

`default_nettype wire

// File: hw/memory_subsystem.sv
/*
  banked RAM
  word-wide banks with byte-enable writes and a one-cycle response
*/
`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_settings.svh"

module memory_subsystem
  import mini_mcu_pkg::*;
#(
  parameter int NUM_BANKS = `NUM_BANKS
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  obi_req_t  ram_req_i,
  output obi_resp_t ram_resp_o
);

  localparam int WORD_W = $clog2(`BANK_WORDS);
  localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic [31:0]       mem [NUM_BANKS][`BANK_WORDS];
  logic [BANK_W-1:0] bank;
  logic [WORD_W-1:0] word;
  logic              rvalid_q;
  logic [31:0]       rdata_q;

  // higher address bits alias
  assign bank = ram_req_i.addr[`RAM_BANK_BIT +: BANK_W];
  assign word = ram_req_i.addr[2 +: WORD_W];

  always_ff @(posedge clk_i) begin
    if (ram_req_i.req) begin
      if (ram_req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (ram_req_i.be[b]) begin
            mem[bank][word][8*b +: 8] <= ram_req_i.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[bank][word];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= ram_req_i.req;
    end
  end

  assign ram_resp_o = '{gnt: ram_req_i.req, rvalid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

// File: hw/dma_engine.sv
/*
  word-copy DMA
  OBI master that reads len words from src and writes them to dst
*/
`timescale 1ns/1ps
`default_nettype none

module dma_engine
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        start_i,
  input  logic [31:0] src_i,
  input  logic [31:0] dst_i,
  input  logic [15:0] len_i,
  output logic        busy_o,
  output logic        done_o,
  output obi_req_t    dma_req_o,
  input  obi_resp_t   dma_resp_i
);

  typedef enum logic [2:0] {
    IDLE,
    READ,
    WAIT_DATA,
    WRITE,
    WAIT_ACK
  } state_e;

  state_e      state_q;
  logic [31:0] rd_addr_q;
  logic [31:0] wr_addr_q;
  logic [15:0] remain_q;
  logic [31:0] data_q;
  logic        last_ack;

  assign last_ack = (state_q == WAIT_ACK) & dma_resp_i.rvalid & (remain_q == 16'd1);
  assign busy_o   = (state_q != IDLE);
  assign done_o   = last_ack | ((state_q == IDLE) & start_i & (len_i == 16'd0));

  always_comb begin
    dma_req_o.req   = (state_q == READ) | (state_q == WRITE);
    dma_req_o.we    = (state_q == WRITE);
    dma_req_o.be    = 4'hF;
    dma_req_o.addr  = (state_q == WRITE) ? wr_addr_q : rd_addr_q;
    dma_req_o.wdata = data_q;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      rd_addr_q <= '0;
      wr_addr_q <= '0;
      remain_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i && len_i != 16'd0) begin
            rd_addr_q <= src_i;
            wr_addr_q <= dst_i;
            remain_q  <= len_i;
            state_q   <= READ;
          end
        end
        READ: begin
          if (dma_resp_i.gnt) state_q <= WAIT_DATA;
        end
        WAIT_DATA: begin
          if (dma_resp_i.rvalid) state_q <= WRITE;
        end
        WRITE: begin
          if (dma_resp_i.gnt) state_q <= WAIT_ACK;
        end
        WAIT_ACK: begin
          if (dma_resp_i.rvalid) begin
            rd_addr_q <= rd_addr_q + 32'd4;
            wr_addr_q <= wr_addr_q + 32'd4;
            remain_q  <= remain_q - 16'd1;
            state_q   <= (remain_q == 16'd1) ? IDLE : READ;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // word in flight between read and write
  always_ff @(posedge clk_i) begin
    if (state_q == WAIT_DATA && dma_resp_i.rvalid) begin
      data_q <= dma_resp_i.rdata;
    end
  end

endmodule

`default_nettype wire

// File: hw/ao_peripheral_subsystem.sv
/*
  always-on peripherals
  exit registers and the DMA configuration, with the DMA engine itself
*/
`timescale 1ns/1ps
`default_nettype none

module ao_peripheral_subsystem
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  obi_req_t    slave_req_i,
  output obi_resp_t   slave_resp_o,
  output obi_req_t    dma_req_o,
  input  obi_resp_t   dma_resp_i,
  output logic [31:0] exit_value_o,
  output logic        exit_valid_o,
  output logic        dma_intr_o
);

  localparam logic [15:0] EXIT_VALID_OFS = 16'h0000;
  localparam logic [15:0] EXIT_VALUE_OFS = 16'h0004;
  localparam logic [15:0] DMA_SRC_OFS    = 16'h0010;
  localparam logic [15:0] DMA_DST_OFS    = 16'h0014;
  localparam logic [15:0] DMA_LEN_OFS    = 16'h0018;
  localparam logic [15:0] DMA_CTRL_OFS   = 16'h001C;

  logic [15:0] offset;
  logic        wr_en;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] dma_src_q;
  logic [31:0] dma_dst_q;
  logic [15:0] dma_len_q;
  logic        done_q;
  logic        dma_start;
  logic        dma_busy;
  logic        dma_done;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic [31:0] rdata_d;

  assign offset = slave_req_i.addr[15:0];
  assign wr_en  = slave_req_i.req & slave_req_i.we;

  // a start while busy is dropped
  assign dma_start = wr_en & (offset == DMA_CTRL_OFS) & slave_req_i.wdata[0] & ~dma_busy;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      dma_src_q    <= '0;
      dma_dst_q    <= '0;
      dma_len_q    <= '0;
      done_q       <= 1'b0;
    end else begin
      if (wr_en) begin
        case (offset)
          EXIT_VALID_OFS: exit_valid_q <= slave_req_i.wdata[0];
          EXIT_VALUE_OFS: exit_value_q <= slave_req_i.wdata;
          DMA_SRC_OFS:    dma_src_q    <= slave_req_i.wdata;
          DMA_DST_OFS:    dma_dst_q    <= slave_req_i.wdata;
          DMA_LEN_OFS:    dma_len_q    <= slave_req_i.wdata[15:0];
          default:        ;
        endcase
      end
      // zero-length copy finishes in its start cycle
      if (dma_done) begin
        done_q <= 1'b1;
      end else if (dma_start) begin
        done_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (offset)
      EXIT_VALID_OFS: rdata_d = {31'b0, exit_valid_q};
      EXIT_VALUE_OFS: rdata_d = exit_value_q;
      DMA_SRC_OFS:    rdata_d = dma_src_q;
      DMA_DST_OFS:    rdata_d = dma_dst_q;
      DMA_LEN_OFS:    rdata_d = {16'b0, dma_len_q};
      DMA_CTRL_OFS:   rdata_d = {30'b0, done_q, dma_busy};
      default:        rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (slave_req_i.req) begin
      rdata_q <= slave_req_i.we ? 32'h0 : rdata_d;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= slave_req_i.req;
    end
  end

  assign slave_resp_o = '{gnt: slave_req_i.req, rvalid: rvalid_q, rdata: rdata_q};
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;
  assign dma_intr_o   = done_q;

  dma_engine dma_engine_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .start_i   (dma_start),
    .src_i     (dma_src_q),
    .dst_i     (dma_dst_q),
    .len_i     (dma_len_q),
    .busy_o    (dma_busy),
    .done_o    (dma_done),
    .dma_req_o (dma_req_o),
    .dma_resp_i(dma_resp_i)
  );

endmodule

`default_nettype wire

// File: hw/mini_mcu.sv
/*
  mini MCU top
  external OBI master, system bus, banked RAM and always-on peripherals
*/
`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_settings.svh"

module mini_mcu
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  obi_req_t    ext_master_req_i,
  output obi_resp_t   ext_master_resp_o,
  output logic [31:0] exit_value_o,
  output logic        exit_valid_o,
  output logic        dma_intr_o
);

  // DMA master
  obi_req_t  dma_req;
  obi_resp_t dma_resp;

  // slaves
  obi_req_t  ram_req;
  obi_resp_t ram_resp;
  obi_req_t  ao_req;
  obi_resp_t ao_resp;

  system_bus system_bus_i (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .ext_master_req_i (ext_master_req_i),
    .ext_master_resp_o(ext_master_resp_o),
    .dma_req_i        (dma_req),
    .dma_resp_o       (dma_resp),
    .ram_req_o        (ram_req),
    .ram_resp_i       (ram_resp),
    .ao_req_o         (ao_req),
    .ao_resp_i        (ao_resp)
  );

  memory_subsystem #(
    .NUM_BANKS(`NUM_BANKS)
  ) memory_subsystem_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .ram_req_i (ram_req),
    .ram_resp_o(ram_resp)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .slave_req_i (ao_req),
    .slave_resp_o(ao_resp),
    .dma_req_o   (dma_req),
    .dma_resp_i  (dma_resp),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o),
    .dma_intr_o  (dma_intr_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_mini_mcu.sv
/*
  mini MCU testbench
  drives the external OBI port, checks RAM, DMA copies and exit registers
*/
`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_settings.svh"

module tb_mini_mcu
  import mini_mcu_pkg::*;
();

  // tests take roughly 4000 cycles
  localparam int MAX_CYCLES = 20000;
  localparam int MAX_POLLS  = 500;
  localparam int MEM_WORDS  = `NUM_BANKS * `BANK_WORDS;

  localparam logic [31:0] REG_EXIT_VALID = `AO_BASE + 32'h00;
  localparam logic [31:0] REG_EXIT_VALUE = `AO_BASE + 32'h04;
  localparam logic [31:0] REG_DMA_SRC    = `AO_BASE + 32'h10;
  localparam logic [31:0] REG_DMA_DST    = `AO_BASE + 32'h14;
  localparam logic [31:0] REG_DMA_LEN    = `AO_BASE + 32'h18;
  localparam logic [31:0] REG_DMA_CTRL   = `AO_BASE + 32'h1C;

  logic        clk = 1'b0;
  logic        arst_n;
  obi_req_t    ext_req;
  obi_resp_t   ext_resp;
  logic [31:0] exit_value;
  logic        exit_valid;
  logic        dma_intr;
  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] rng_state = 32'd40134;
  int          mismatch_count = 0;
  int          fail_count = 0;
  int          cycle_count = 0;

  mini_mcu DUT (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .ext_master_req_i (ext_req),
    .ext_master_resp_o(ext_resp),
    .exit_value_o     (exit_value),
    .exit_valid_o     (exit_valid),
    .dma_intr_o       (dma_intr)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run went past %0d clock cycles", MAX_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // expected memory after a DMA copy
  function automatic void ref_copy(input logic [31:0] src, input logic [31:0] dst, input int len);
    logic [31:0] s;
    logic [31:0] d;
    for (int i = 0; i < len; i++) begin
      s = src + 32'(4 * i);
      d = dst + 32'(4 * i);
      ref_mem[d[`RAM_BANK_BIT:2]] = ref_mem[s[`RAM_BANK_BIT:2]];
    end
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    mismatch_count++;
    $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
  endtask

  // one OBI transfer holding req until gnt
  task automatic bus_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    obi_req_t r;
    int       waits;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    waits   = 0;
    @(posedge clk);
    ext_req <= r;
    @(negedge clk);
    while (!ext_resp.gnt && waits < 100) begin
      @(posedge clk);
      @(negedge clk);
      waits++;
    end
    if (!ext_resp.gnt) begin
      fail_count++;
      $display("no grant for the external access to %h at %0t", addr, $time);
    end
    @(posedge clk);
    ext_req.req <= 1'b0;
    @(negedge clk);
    if (!ext_resp.rvalid) begin
      fail_count++;
      $display("no response for the external access to %h at %0t", addr, $time);
    end
    rdata = ext_resp.rdata;
  endtask

  task automatic ram_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    logic [31:0] rd;
    ref_mem[addr[`RAM_BANK_BIT:2]] = merge_bytes(ref_mem[addr[`RAM_BANK_BIT:2]], data, be);
    bus_access(1'b1, be, addr, data, rd);
    if (rd !== 32'h0) begin
      report_mismatch($sformatf("ram write response %h", addr), rd, 32'h0);
    end
  endtask

  task automatic ram_check(input logic [31:0] addr);
    logic [31:0] rd;
    bus_access(1'b0, 4'hF, addr, 32'h0, rd);
    if (rd !== ref_mem[addr[`RAM_BANK_BIT:2]]) begin
      report_mismatch($sformatf("ram word %h", addr), rd, ref_mem[addr[`RAM_BANK_BIT:2]]);
    end
  endtask

  task automatic ao_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    bus_access(1'b1, 4'hF, addr, data, rd);
    if (rd !== 32'h0) begin
      report_mismatch($sformatf("AO write response %h", addr), rd, 32'h0);
    end
  endtask

  task automatic ao_expect(input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    bus_access(1'b0, 4'hF, addr, 32'h0, rd);
    if (rd !== exp) report_mismatch($sformatf("AO register %h", addr), rd, exp);
  endtask

  task automatic dma_wait_done();
    logic [31:0] rd;
    int          polls;
    rd    = 32'h0;
    polls = 0;
    while (rd[1] !== 1'b1 && polls < MAX_POLLS) begin
      bus_access(1'b0, 4'hF, REG_DMA_CTRL, 32'h0, rd);
      polls++;
    end
    if (rd[1] !== 1'b1 || rd[0] !== 1'b0) begin
      fail_count++;
      $display("DMA copy did not finish within %0d status polls", MAX_POLLS);
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] rd;
    logic [31:0] exit_word;
    ext_req <= '0;
    arst_n  <= 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);

    // outputs and DMA status straight out of reset
    if (exit_value !== 32'h0) report_mismatch("exit_value_o after reset", exit_value, 32'h0);
    if (exit_valid !== 1'b0 || dma_intr !== 1'b0) begin
      report_mismatch("exit_valid_o, dma_intr_o after reset", {30'b0, exit_valid, dma_intr},
                      32'h0);
    end
    ao_expect(REG_DMA_CTRL, 32'h0);

    // fill both banks then scatter byte writes through aliased addresses
    for (int i = 0; i < MEM_WORDS; i++) ram_write(32'(i) << 2, next_random(), 4'hF);
    for (int i = 0; i < 200; i++) begin
      rnd = next_random();
      ram_write(rnd & 32'h0000_FFFC, next_random(), rnd[19:16]);
    end
    for (int i = 0; i < MEM_WORDS; i++) ram_check(32'(i) << 2);

    // DMA config readback and unmapped offsets
    ao_write(REG_DMA_SRC, 32'h0000_0040);
    ao_write(REG_DMA_DST, 32'h0000_0480);
    ao_write(REG_DMA_LEN, 32'hABCD_0020);
    ao_write(`AO_BASE + 32'h08, 32'hFFFF_FFFF);
    ao_expect(REG_DMA_SRC, 32'h0000_0040);
    ao_expect(REG_DMA_DST, 32'h0000_0480);
    ao_expect(REG_DMA_LEN, 32'h0000_0020);
    ao_expect(`AO_BASE + 32'h08, 32'h0);
    ao_expect(`AO_BASE + 32'h0C, 32'h0);
    ao_expect(`AO_BASE + 32'h20, 32'h0);

    // copy 32 words bank 0 to bank 1
    ao_write(REG_DMA_CTRL, 32'h1);
    dma_wait_done();
    if (dma_intr !== 1'b1) report_mismatch("dma_intr_o after copy", {31'b0, dma_intr}, 32'h1);
    ref_copy(32'h0000_0040, 32'h0000_0480, 32);
    for (int i = 0; i < 32; i++) begin
      ram_check(32'h0000_0040 + 32'(4 * i));
      ram_check(32'h0000_0480 + 32'(4 * i));
    end

    // second copy with external traffic to an unrelated region
    ao_write(REG_DMA_SRC, 32'h0000_0600);
    ao_write(REG_DMA_DST, 32'h0000_0200);
    ao_write(REG_DMA_LEN, 32'h0000_0030);
    ao_write(REG_DMA_CTRL, 32'h1);
    if (dma_intr !== 1'b0) report_mismatch("dma_intr_o after start", {31'b0, dma_intr}, 32'h0);
    bus_access(1'b0, 4'hF, REG_DMA_CTRL, 32'h0, rd);
    if (rd !== 32'h1) report_mismatch("DMA_CTRL while copying", rd, 32'h1);
    for (int i = 0; i < 16; i++) begin
      rnd = next_random();
      ram_write(32'h0000_03C0 + 32'(4 * i), next_random(), rnd[3:0]);
    end
    dma_wait_done();
    ref_copy(32'h0000_0600, 32'h0000_0200, 48);
    for (int i = 0; i < 48; i++) begin
      ram_check(32'h0000_0600 + 32'(4 * i));
      ram_check(32'h0000_0200 + 32'(4 * i));
    end
    for (int i = 0; i < 16; i++) ram_check(32'h0000_03C0 + 32'(4 * i));

    // exit registers
    exit_word = next_random();
    ao_write(REG_EXIT_VALUE, exit_word);
    ao_write(REG_EXIT_VALID, 32'h1);
    if (exit_value !== exit_word) report_mismatch("exit_value_o", exit_value, exit_word);
    if (exit_valid !== 1'b1) report_mismatch("exit_valid_o", {31'b0, exit_valid}, 32'h1);

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/mini_mcu_properties.sv
/*
  mini MCU properties
  checks on the external OBI port and the exit outputs
*/
`timescale 1ns/1ps
`default_nettype none

`include "mini_mcu_settings.svh"

module mini_mcu_properties
  import mini_mcu_pkg::*;
(
  input logic      clk_i,
  input logic      arst_n_i,
  input obi_req_t  ext_master_req_i,
  input obi_resp_t ext_master_resp_o,
  input logic      exit_valid_o
);

  slave_sel_e ext_sel;

  assign ext_sel = ((ext_master_req_i.addr & `AO_BASE) != 32'h0) ? AO : RAM;

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ext_master_resp_o.gnt |-> ext_master_req_i.req)
    else $error("external gnt without req");

  gnt_then_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ext_master_resp_o.gnt |=> ext_master_resp_o.rvalid)
    else $error("external gnt not followed by rvalid");

  // external master has priority, so RAM never stalls it
  ram_gnt_at_once: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ext_master_req_i.req && ext_sel == RAM) |-> ext_master_resp_o.gnt)
    else $error("external RAM request not granted in its cycle");

  exit_low_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> !exit_valid_o)
    else $error("exit_valid_o set during reset");

endmodule

bind mini_mcu mini_mcu_properties mini_mcu_properties_i (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .ext_master_req_i (ext_master_req_i),
  .ext_master_resp_o(ext_master_resp_o),
  .exit_valid_o     (exit_valid_o)
);

`default_nettype wire

// File: mini_mcu.f
+incdir+hw
hw/mini_mcu_pkg.sv
hw/system_bus.sv
hw/memory_subsystem.sv
hw/dma_engine.sv
hw/ao_peripheral_subsystem.sv
hw/mini_mcu.sv
sim/tb_mini_mcu.sv
sim/mini_mcu_properties.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the mini MCU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mini_mcu \
  -f mini_mcu.f -o tb_mini_mcu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_mini_mcu)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
